//--- filelist.f
sha256_pkg.sv
sha256_round.sv
sha256_msg_sched.sv
sha256_block_padder.sv
sha256_ctrl.sv
sha256_core.sv
sha256_core_assertions.sv
sha256_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SHA-256 core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module sha256_core_tb -f filelist.f \
	> build.log 2>&1 \
	&& ./obj_dir/Vsha256_core_tb > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- sha256_block_padder.sv
`timescale 1ns/1ps

module sha256_block_padder (
	input                                         clk,
	input                                         rst_n,
	input  logic                                  accept_i,
	input  logic                                  block_first_i,
	input  logic                                  block_final_i,
	input  logic [sha256_pkg::LEN_W-1:0]          len_i,
	input  sha256_pkg::block_u                    block_i,
	output sha256_pkg::block_u                    block_o
);
	import sha256_pkg::*;

	logic [MSG_LEN_W-1:0] msg_cnt;   // bytes before the current block
	logic [MSG_LEN_W-1:0] total_len; // including this block
	logic                 do_pad;

	assign total_len = block_first_i ? MSG_LEN_W'(len_i) : msg_cnt + MSG_LEN_W'(len_i);
	assign do_pad    = block_final_i && (len_i <= LEN_W'(MAX_FINAL_BYTES));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			msg_cnt <= '0;
		end else if (accept_i) begin
			if (block_first_i || block_final_i) begin
				msg_cnt <= total_len;
			end else begin
				msg_cnt <= msg_cnt + MSG_LEN_W'(BLOCK_BYTES);
			end
		end
	end

	// --------------------------------------------------
	// padding of a short final block
	// --------------------------------------------------
	always_comb begin
		block_o = block_i;
		if (do_pad) begin
			for (int i = 0; i < BLOCK_BYTES - 8; i++) begin
				if (i == int'(len_i)) begin
					block_o.bytes[i] = PAD_BYTE;
				end else if (i > int'(len_i)) begin
					block_o.bytes[i] = 8'h00;
				end
			end
			// message length in bits, big endian
			{block_o.words[14], block_o.words[15]} = {total_len, 3'b000};
		end
	end

endmodule

//--- sha256_core.sv
`timescale 1ns/1ps

module sha256_core (
	input                                 clk,
	input                                 rst_n,
	input  logic                          start_i,
	input  logic                          block_first_i,
	input  logic                          block_final_i,
	input  logic [sha256_pkg::LEN_W-1:0]  len_i,
	input  sha256_pkg::state_t            state_i,
	input  sha256_pkg::block_u            block_i,
	output logic                          dout_vld_o,
	output sha256_pkg::state_t            state_o
);
	import sha256_pkg::*;

	logic   accept;
	logic   compress;
	logic   finish;
	group_t group;

	block_u                         padded_block;
	word_t [0:ROUNDS_PER_CYCLE-1]   w_cur;
	word_t                          k_cur [0:ROUNDS_PER_CYCLE-1];
	state_t                         rnd_vars [0:ROUNDS_PER_CYCLE];

	state_t vars_q;     // working variables a..h
	state_t chain_q;    // feed-forward copy
	state_t init_state;
	state_t sum_state;

	// --------------------------------------------------
	// control, padding, schedule
	// --------------------------------------------------
	sha256_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.start_i    (start_i),
		.compress_o (compress),
		.accept_o   (accept),
		.finish_o   (finish),
		.group_o    (group)
	);

	sha256_block_padder u_padder (
		.clk           (clk),
		.rst_n         (rst_n),
		.accept_i      (accept),
		.block_first_i (block_first_i),
		.block_final_i (block_final_i),
		.len_i         (len_i),
		.block_i       (block_i),
		.block_o       (padded_block)
	);

	sha256_msg_sched u_sched (
		.clk        (clk),
		.accept_i   (accept),
		.compress_i (compress),
		.group_i    (group),
		.block_i    (padded_block),
		.w_o        (w_cur)
	);

	// --------------------------------------------------
	// eight chained rounds per cycle
	// --------------------------------------------------
	assign rnd_vars[0] = vars_q;

	for (genvar i = 0; i < ROUNDS_PER_CYCLE; i++) begin : g_round
		assign k_cur[i] = K_TABLE[int'(group) * ROUNDS_PER_CYCLE + i];

		sha256_round u_round (
			.vars_i (rnd_vars[i]),
			.w_i    (w_cur[i]),
			.k_i    (k_cur[i]),
			.vars_o (rnd_vars[i+1])
		);
	end

	assign init_state = block_first_i ? IV : state_i;

	always_ff @(posedge clk) begin
		if (accept) begin
			vars_q  <= init_state;
			chain_q <= init_state;
		end else if (compress) begin
			vars_q <= rnd_vars[ROUNDS_PER_CYCLE];
		end
	end

	// feed-forward, word by word
	always_comb begin
		sum_state.a = vars_q.a + chain_q.a;
		sum_state.b = vars_q.b + chain_q.b;
		sum_state.c = vars_q.c + chain_q.c;
		sum_state.d = vars_q.d + chain_q.d;
		sum_state.e = vars_q.e + chain_q.e;
		sum_state.f = vars_q.f + chain_q.f;
		sum_state.g = vars_q.g + chain_q.g;
		sum_state.h = vars_q.h + chain_q.h;
	end

	always_ff @(posedge clk) begin
		if (finish) begin
			state_o <= sum_state; // held until the next block finishes
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dout_vld_o <= 1'b0;
		end else begin
			dout_vld_o <= finish;
		end
	end

endmodule

//--- sha256_core_assertions.sv
`timescale 1ns/1ps

module sha256_core_assertions (
	input logic clk,
	input logic rst_n,
	input logic accept_i,
	input logic dout_vld_i
);

	// --------------------------------------------------
	// valid pulse timing
	// --------------------------------------------------
	vld_low_in_reset: assert property (@(posedge clk) !rst_n |-> !dout_vld_i)
		else $error("dout_vld_o high while rst_n is asserted");

	vld_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		dout_vld_i |=> !dout_vld_i)
		else $error("dout_vld_o high for two cycles in a row");

	// registered at the ninth edge after accept, sampled at the tenth
	vld_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		accept_i |-> ##10 dout_vld_i)
		else $error("no dout_vld_o pulse nine edges after an accepted start");

endmodule

//--- sha256_core_tb.sv
`timescale 1ns/1ps

module sha256_core_tb;
	import sha256_pkg::*;

	localparam state_t ABC_DIGEST = {
		32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
		32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
	};

	logic             clk;
	logic             rst_n;
	logic             start_i;
	logic             block_first_i;
	logic             block_final_i;
	logic [LEN_W-1:0] len_i;
	state_t           state_i;
	block_u           block_i;
	logic             dout_vld_o;
	state_t           state_o;

	int     seed = 92498;
	int     err_cnt = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	state_t exp_q [$]; // expected results in issue order

	sha256_core sha256_core_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.start_i       (start_i),
		.block_first_i (block_first_i),
		.block_final_i (block_final_i),
		.len_i         (len_i),
		.state_i       (state_i),
		.block_i       (block_i),
		.dout_vld_o    (dout_vld_o),
		.state_o       (state_o)
	);

	bind sha256_core sha256_core_assertions u_assertions (
		.clk        (clk),
		.rst_n      (rst_n),
		.accept_i   (accept),
		.dout_vld_i (dout_vld_o)
	);

	always #4 clk = ~clk;

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic state_t sha256_compress_ref(input state_t st, input block_u blk);
		word_t w [0:63];
		word_t a, b, c, d, e, f, g, h;
		word_t s0, s1, t1, t2;
		for (int t = 0; t < 64; t++) begin
			if (t < 16) begin
				w[t] = blk.words[t];
			end else begin
				s0 = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
				s1 = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
				w[t] = s1 + w[t-7] + s0 + w[t-16];
			end
		end
		{a, b, c, d, e, f, g, h} = st;
		for (int t = 0; t < 64; t++) begin
			t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g))
				+ K_TABLE[t] + w[t];
			t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
			h = g;
			g = f;
			f = e;
			e = d + t1;
			d = c;
			c = b;
			b = a;
			a = t1 + t2;
		end
		return {st.a + a, st.b + b, st.c + c, st.d + d,
			st.e + e, st.f + f, st.g + g, st.h + h};
	endfunction

	// final block as the standard pads it, total in bytes
	function automatic block_u pad_ref(input block_u blk, input int len, input int total);
		block_u      p;
		logic [63:0] bit_len;
		p = blk;
		for (int i = len; i < 56; i++) begin
			p.bytes[i] = (i == len) ? 8'h80 : 8'h00;
		end
		bit_len = 64'(total) << 3;
		{p.words[14], p.words[15]} = bit_len;
		return p;
	endfunction

	function automatic block_u rand_block();
		block_u b;
		for (int i = 0; i < 16; i++) begin
			b.words[i] = $random(seed);
		end
		return b;
	endfunction

	function automatic state_t rand_state();
		state_t s;
		for (int i = 0; i < 8; i++) begin
			s[i*32 +: 32] = $random(seed);
		end
		return s;
	endfunction

	// --------------------------------------------------
	// comparison of every valid pulse
	// --------------------------------------------------
	always @(posedge clk) begin
		if (rst_n && dout_vld_o) begin
			if (exp_q.size() == 0) begin
				$display("unexpected dout_vld_o pulse with no block pending at %0t", $time);
				err_cnt++;
			end else if (state_o !== exp_q[0]) begin
				$display("CHECK FAILED at %0t: state_o %h, expected %h", $time, state_o, exp_q[0]);
				err_cnt++;
				void'(exp_q.pop_front());
			end else begin
				void'(exp_q.pop_front());
			end
		end
	end

	// poke sends extra start strobes while the block is busy
	task automatic run_block(input logic first_blk, input logic last_blk, input int len,
		input state_t st, input block_u blk, input state_t exp, input logic poke,
		output state_t res);
		int     cnt;
		state_t prev;
		prev = state_o; // old result must stay until the pulse
		exp_q.push_back(exp);
		@(posedge clk);
		start_i       <= 1'b1;
		block_first_i <= first_blk;
		block_final_i <= last_blk;
		len_i         <= LEN_W'(len);
		state_i       <= st;
		block_i       <= blk;
		@(posedge clk); // accepting edge
		start_i <= 1'b0;
		cnt = 0;
		while (!dout_vld_o && cnt < 20) begin
			@(posedge clk);
			cnt++;
			if (!dout_vld_o && state_o !== prev) begin
				$display("CHECK FAILED at %0t: state_o %h changed before dout_vld_o",
					$time, state_o);
				err_cnt++;
			end
			start_i <= poke && (cnt == 3 || cnt == 8); // mid compress, finish cycle
			if (poke) begin
				block_i <= rand_block();
			end
		end
		if (!dout_vld_o) begin
			$display("timeout: no dout_vld_o within 20 cycles after start at %0t", $time);
			err_cnt++;
			exp_q.delete();
		end
		res = state_o;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (err_cnt > err_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_cnt - err_before);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		state_t res;
		state_t model;
		state_t held;
		block_u blk;
		int     len;
		int     err_before;

		clk           = 1'b0;
		rst_n         = 1'b0;
		start_i       = 1'b0;
		block_first_i = 1'b0;
		block_final_i = 1'b0;
		len_i         = '0;
		state_i       = '0;
		block_i       = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		err_before = err_cnt;
		blk = '0;
		blk.bytes[0] = 8'h61; // "abc"
		blk.bytes[1] = 8'h62;
		blk.bytes[2] = 8'h63;
		if (sha256_compress_ref(IV, pad_ref(blk, 3, 3)) !== ABC_DIGEST) begin
			$display("CHECK FAILED at %0t: reference model disagrees with the abc digest", $time);
			err_cnt++;
		end
		run_block(1'b1, 1'b1, 3, rand_state(), blk, ABC_DIGEST, 1'b0, res);
		end_test("abc vector", err_before);

		err_before = err_cnt;
		for (int n = 0; n < 4; n++) begin
			blk = rand_block();
			run_block(1'b1, 1'b0, 64, rand_state(), blk, sha256_compress_ref(IV, blk), 1'b0, res);
		end
		end_test("random single blocks", err_before);

		// two full blocks and a short final one, output fed back each time
		err_before = err_cnt;
		blk = rand_block();
		model = sha256_compress_ref(IV, blk);
		run_block(1'b1, 1'b0, 64, rand_state(), blk, model, 1'b0, res);
		blk = rand_block();
		model = sha256_compress_ref(model, blk);
		run_block(1'b0, 1'b0, 64, res, blk, model, 1'b0, res);
		blk = rand_block();
		len = 1 + ($unsigned($random(seed)) % 55);
		model = sha256_compress_ref(model, pad_ref(blk, len, 128 + len));
		run_block(1'b0, 1'b1, len, res, blk, model, 1'b0, res);
		end_test("chained message", err_before);

		err_before = err_cnt;
		blk = rand_block();
		run_block(1'b1, 1'b0, 64, rand_state(), blk, sha256_compress_ref(IV, blk), 1'b1, res);
		repeat (12) @(posedge clk); // room for a stray pulse
		end_test("start while busy", err_before);

		err_before = err_cnt;
		held = state_o;
		for (int n = 0; n < 6; n++) begin
			@(posedge clk);
			if (state_o !== held) begin
				$display("CHECK FAILED at %0t: state_o changed to %h while idle", $time, state_o);
				err_cnt++;
			end
		end
		// short reset in the middle of a block, which must then never finish
		@(posedge clk);
		start_i       <= 1'b1;
		block_first_i <= 1'b1;
		block_final_i <= 1'b0;
		len_i         <= LEN_W'(64);
		block_i       <= rand_block();
		@(posedge clk);
		start_i <= 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		for (int n = 0; n < 15; n++) begin
			@(posedge clk);
			if (dout_vld_o !== 1'b0) begin
				$display("CHECK FAILED at %0t: dout_vld_o high after reset", $time);
				err_cnt++;
			end
		end
		blk = rand_block();
		run_block(1'b1, 1'b0, 64, rand_state(), blk, sha256_compress_ref(IV, blk), 1'b0, res);
		end_test("output hold and reset", err_before);

		$display("%0d tests run, %0d passed, %0d failed, %0d check errors",
			tests_run, tests_run - tests_failed, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- sha256_ctrl.sv
`timescale 1ns/1ps

module sha256_ctrl (
	input                            clk,
	input                            rst_n,
	input  logic                     start_i,
	output logic                     compress_o,
	output logic                     accept_o,
	output logic                     finish_o,
	output sha256_pkg::group_t       group_o
);
	import sha256_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COMPRESS,
		ST_FINISH
	} ctrl_state_e;

	ctrl_state_e state_q;
	group_t      group_q;
	logic        last_group;

	assign last_group = (group_q == group_t'(NUM_GROUPS - 1));

	// --------------------------------------------------
	// FSM and round-group counter
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			group_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (start_i) begin
						state_q <= ST_COMPRESS;
						group_q <= '0;
					end
				end
				ST_COMPRESS: begin
					group_q <= group_q + 1'b1; // wraps to 0 after the last group
					if (last_group) begin
						state_q <= ST_FINISH;
					end
				end
				ST_FINISH: begin
					state_q <= ST_IDLE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	assign accept_o   = (state_q == ST_IDLE) && start_i; // busy strobes dropped
	assign compress_o = (state_q == ST_COMPRESS);
	assign finish_o   = (state_q == ST_FINISH);
	assign group_o    = group_q;

endmodule

//--- sha256_msg_sched.sv
`timescale 1ns/1ps

module sha256_msg_sched (
	input                                                    clk,
	input  logic                                             accept_i,
	input  logic                                             compress_i,
	input  sha256_pkg::group_t                               group_i,
	input  sha256_pkg::block_u                               block_i,
	output sha256_pkg::word_t [0:sha256_pkg::ROUNDS_PER_CYCLE-1] w_o
);
	import sha256_pkg::*;

	// --------------------------------------------------
	// sixteen-word window plus eight fresh words
	// --------------------------------------------------
	word_t [0:15] win;
	word_t [0:23] ext; // window in time order, then the new words
	logic         expand;

	function automatic word_t small_sig0(input word_t x);
		return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
	endfunction

	function automatic word_t small_sig1(input word_t x);
		return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
	endfunction

	assign expand = compress_i && (group_i < group_t'(EXPAND_GROUPS));

	always_comb begin
		// odd groups: upper half is older, so rotate it to the front
		if (group_i[0]) begin
			ext[0:15] = {win[8:15], win[0:7]};
		end else begin
			ext[0:15] = win;
		end

		// W[t] = s1(W[t-2]) + W[t-7] + s0(W[t-15]) + W[t-16]
		for (int j = 0; j < ROUNDS_PER_CYCLE; j++) begin
			ext[16+j] = small_sig1(ext[j+14]) + ext[j+9] + small_sig0(ext[j+1]) + ext[j];
		end
	end

	assign w_o = ext[0:ROUNDS_PER_CYCLE-1]; // half presented this group

	// --------------------------------------------------
	// window update
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept_i) begin
			win <= block_i.words;
		end else if (expand) begin
			if (group_i[0]) begin
				win[8:15] <= ext[16:23];
			end else begin
				win[0:7] <= ext[16:23];
			end
		end
	end

endmodule

//--- sha256_pkg.sv
package sha256_pkg;

	// --------------------------------------------------
	// widths and counts
	// --------------------------------------------------
	localparam int WORD_W           = 32;
	localparam int ROUNDS_PER_CYCLE = 8;
	localparam int NUM_GROUPS       = 8;  // 64 rounds / 8 per cycle
	localparam int EXPAND_GROUPS    = 6;  // W16..W63
	localparam int BLOCK_BYTES      = 64;
	localparam int MAX_FINAL_BYTES  = 55; // leaves room for 0x80 and the length field
	localparam int LEN_W            = 7;
	localparam int MSG_LEN_W        = 61; // bytes, so bit length fits in 64

	localparam logic [7:0] PAD_BYTE = 8'h80;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [2:0] group_t;

	// word a sits in the top bits
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} state_t;

	// byte 0 and word 0 are the most significant
	typedef union packed {
		logic [0:BLOCK_BYTES-1][7:0] bytes;
		word_t [0:BLOCK_BYTES/4-1] words;
	} block_u;

	// --------------------------------------------------
	// constants
	// --------------------------------------------------
	localparam state_t IV = '{
		a: 32'h6a09e667,
		b: 32'hbb67ae85,
		c: 32'h3c6ef372,
		d: 32'ha54ff53a,
		e: 32'h510e527f,
		f: 32'h9b05688c,
		g: 32'h1f83d9ab,
		h: 32'h5be0cd19
	};

	// round constants, entry 0 first
	localparam word_t [0:63] K_TABLE = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage

//--- sha256_round.sv
`timescale 1ns/1ps

module sha256_round (
	input  sha256_pkg::state_t vars_i,
	input  sha256_pkg::word_t  w_i,
	input  sha256_pkg::word_t  k_i,
	output sha256_pkg::state_t vars_o
);
	import sha256_pkg::*;

	word_t t1;
	word_t t2;

	function automatic word_t big_sig0(input word_t x);
		return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
	endfunction

	function automatic word_t big_sig1(input word_t x);
		return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
	endfunction

	always_comb begin
		// ch(e,f,g) and maj(a,b,c) folded in
		t1 = vars_i.h + big_sig1(vars_i.e) + ((vars_i.e & vars_i.f) ^ (~vars_i.e & vars_i.g))
			+ k_i + w_i;
		t2 = big_sig0(vars_i.a) + ((vars_i.a & vars_i.b) ^ (vars_i.a & vars_i.c)
			^ (vars_i.b & vars_i.c));

		vars_o.a = t1 + t2;
		vars_o.b = vars_i.a;
		vars_o.c = vars_i.b;
		vars_o.d = vars_i.c;
		vars_o.e = vars_i.d + t1;
		vars_o.f = vars_i.e;
		vars_o.g = vars_i.f;
		vars_o.h = vars_i.g;
	end

endmodule
